// ==== include/mos8_consts.svh ====
`ifndef MOS8_CONSTS_SVH
`define MOS8_CONSTS_SVH

// Stack lives in page 1 and its pointer counts down
`define STACK_PAGE 8'h01
`define SP_RESET 8'hFF

// Only the reserved bit after reset
`define P_RESET 8'h20

// Reserved and B bits as seen in a pushed status byte
`define P_PUSH_MASK 8'h30

// Status bit positions
`define ST_N 7
`define ST_V 6
`define ST_Z 1
`define ST_C 0

`endif

// ==== logic/mos8_isa_pkg.sv ====
`default_nettype none

package mos8_isa_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;

	// Supported opcodes with their 6502 encodings
	typedef enum logic [7:0] {
		LDA_IMM = 8'hA9,
		LDX_IMM = 8'hA2,
		ADC_IMM = 8'h69,
		SBC_IMM = 8'hE9,
		AND_IMM = 8'h29,
		ORA_IMM = 8'h09,
		EOR_IMM = 8'h49,
		// Accumulator shifts and rotates
		ASL_A = 8'h0A,
		LSR_A = 8'h4A,
		ROL_A = 8'h2A,
		ROR_A = 8'h6A,
		// Implied
		CLC = 8'h18,
		SEC = 8'h38,
		TAX = 8'hAA,
		TXA = 8'h8A,
		INX = 8'hE8,
		// Zero page stores and push
		STA_ZP = 8'h85,
		STX_ZP = 8'h86,
		PHP = 8'h08
	} opcode_t;

endpackage

`default_nettype wire

// ==== logic/mos8_uop_pkg.sv ====
`default_nettype none

package mos8_uop_pkg;

	// Rotates are shifts with the carry taken in
	typedef enum logic [3:0] {
		ALU_PASS = 4'h0,
		ALU_ADD = 4'h1,
		ALU_SUB = 4'h2,
		ALU_AND = 4'h3,
		ALU_OR = 4'h4,
		ALU_EOR = 4'h5,
		ALU_SHL = 4'h6,
		ALU_SHR = 4'h7,
		ALU_INC = 4'h8
	} alu_op_t;

	// ALU a input
	typedef enum logic [1:0] {SRC_ARG = 2'h0, SRC_A = 2'h1, SRC_X = 2'h2} src_t;

	typedef enum logic [1:0] {DST_NONE = 2'h0, DST_A = 2'h1, DST_X = 2'h2} dst_t;

	// Flags written back to P
	typedef enum logic [2:0] {
		FLG_NONE = 3'h0,
		FLG_NZ = 3'h1,
		FLG_NZC = 3'h2,
		FLG_NVZC = 3'h3,
		FLG_CLR_C = 3'h4,
		FLG_SET_C = 3'h5
	} flag_upd_t;

	typedef enum logic [1:0] {
		STORE_NONE = 2'h0,
		STORE_A_ZP = 2'h1,
		STORE_X_ZP = 2'h2,
		STORE_PUSH_P = 2'h3
	} store_t;

endpackage

`default_nettype wire

// ==== logic/mos8_fetch.sv ====
`default_nettype none

module mos8_fetch import mos8_isa_pkg::*; (
	input logic clk,
	input logic n_reset,
	input logic byte_valid,
	input byte_t byte_data,
	output logic ins_valid,
	output byte_t ins_op,
	output byte_t ins_arg
);

typedef enum logic {WAIT_OP = 1'b0, WAIT_ARG = 1'b1} fetch_state_t;

fetch_state_t state;
logic one_byte;

// Implied and accumulator forms have bit 3 set and bit 0 clear
assign one_byte = byte_data[3] & ~byte_data[0];

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		state <= WAIT_OP;
		ins_valid <= 1'b0;
	end else begin
		ins_valid <= 1'b0;
		if (byte_valid) begin
			case (state)
			WAIT_OP:
				if (one_byte)
					ins_valid <= 1'b1;
				else
					state <= WAIT_ARG;
			WAIT_ARG: begin
				ins_valid <= 1'b1;
				state <= WAIT_OP;
			end
			default: state <= WAIT_OP;
			endcase
		end
	end

// ins_op holds the opcode while the operand is outstanding
always_ff @(posedge clk)
	if (byte_valid) begin
		if (state == WAIT_OP) begin
			ins_op <= byte_data;
			ins_arg <= 8'h00;
		end else begin
			ins_arg <= byte_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mos8_decode.sv ====
`default_nettype none

module mos8_decode import mos8_isa_pkg::*, mos8_uop_pkg::*; (
	input logic clk,
	input logic n_reset,
	input logic ins_valid,
	input byte_t ins_op,
	input byte_t ins_arg,
	output logic uop_valid,
	output alu_op_t uop_alu,
	output src_t uop_src,
	output dst_t uop_dst,
	output flag_upd_t uop_flags,
	output store_t uop_store,
	output logic uop_carry_in,
	output byte_t uop_arg,
	output logic illegal
);

alu_op_t dec_alu;
src_t dec_src;
dst_t dec_dst;
flag_upd_t dec_flags;
store_t dec_store;
logic dec_carry_in;
logic legal;

always_comb begin
	dec_alu = ALU_PASS;
	dec_src = SRC_A;
	dec_dst = DST_NONE;
	dec_flags = FLG_NONE;
	dec_store = STORE_NONE;
	dec_carry_in = 1'b0;
	legal = 1'b1;
	case (opcode_t'(ins_op))
	LDA_IMM:	{dec_src, dec_dst, dec_flags} = {SRC_ARG, DST_A, FLG_NZ};
	LDX_IMM:	{dec_src, dec_dst, dec_flags} = {SRC_ARG, DST_X, FLG_NZ};
	ADC_IMM:	{dec_alu, dec_dst, dec_flags} = {ALU_ADD, DST_A, FLG_NVZC};
	SBC_IMM:	{dec_alu, dec_dst, dec_flags} = {ALU_SUB, DST_A, FLG_NVZC};
	AND_IMM:	{dec_alu, dec_dst, dec_flags} = {ALU_AND, DST_A, FLG_NZ};
	ORA_IMM:	{dec_alu, dec_dst, dec_flags} = {ALU_OR, DST_A, FLG_NZ};
	EOR_IMM:	{dec_alu, dec_dst, dec_flags} = {ALU_EOR, DST_A, FLG_NZ};
	ASL_A:		{dec_alu, dec_dst, dec_flags} = {ALU_SHL, DST_A, FLG_NZC};
	LSR_A:		{dec_alu, dec_dst, dec_flags} = {ALU_SHR, DST_A, FLG_NZC};
	ROL_A: begin
		{dec_alu, dec_dst, dec_flags} = {ALU_SHL, DST_A, FLG_NZC};
		dec_carry_in = 1'b1;
	end
	ROR_A: begin
		{dec_alu, dec_dst, dec_flags} = {ALU_SHR, DST_A, FLG_NZC};
		dec_carry_in = 1'b1;
	end
	CLC:		dec_flags = FLG_CLR_C;
	SEC:		dec_flags = FLG_SET_C;
	TAX:		{dec_src, dec_dst, dec_flags} = {SRC_A, DST_X, FLG_NZ};
	TXA:		{dec_src, dec_dst, dec_flags} = {SRC_X, DST_A, FLG_NZ};
	INX: begin
		{dec_alu, dec_src} = {ALU_INC, SRC_X};
		{dec_dst, dec_flags} = {DST_X, FLG_NZ};
	end
	STA_ZP:		dec_store = STORE_A_ZP;
	STX_ZP:		dec_store = STORE_X_ZP;
	PHP:		dec_store = STORE_PUSH_P;
	default:	legal = 1'b0;
	endcase
end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		uop_valid <= 1'b0;
		illegal <= 1'b0;
	end else begin
		uop_valid <= ins_valid & legal;
		illegal <= ins_valid & ~legal;
	end

always_ff @(posedge clk) begin
	uop_alu <= dec_alu;
	uop_src <= dec_src;
	uop_dst <= dec_dst;
	uop_flags <= dec_flags;
	uop_store <= dec_store;
	uop_carry_in <= dec_carry_in;
	uop_arg <= ins_arg;
end

endmodule

`default_nettype wire

// ==== logic/mos8_alu.sv ====
`default_nettype none

module mos8_alu import mos8_isa_pkg::*, mos8_uop_pkg::*; (
	input alu_op_t op,
	input byte_t a,
	input byte_t b,
	input logic carry,
	input logic carry_in_en,
	output byte_t result,
	output logic carry_out,
	output logic overflow
);

byte_t bi;
logic [8:0] sum;
logic shift_c;

// Subtract is add of the inverted operand
assign bi = (op == ALU_SUB) ? ~b : b;
assign sum = {1'b0, a} + {1'b0, bi} + {8'h00, carry};

// Rotates bring the old carry into the vacated bit
assign shift_c = carry_in_en & carry;

always_comb begin
	result = a;
	carry_out = 1'b0;
	overflow = 1'b0;
	case (op)
	ALU_PASS:
		result = a;
	ALU_ADD, ALU_SUB: begin
		{carry_out, result} = sum;
		// Signed overflow when both inputs agree in sign and the sum does not
		overflow = ~(a[7] ^ bi[7]) & (a[7] ^ sum[7]);
	end
	ALU_AND:
		result = a & b;
	ALU_OR:
		result = a | b;
	ALU_EOR:
		result = a ^ b;
	ALU_SHL:
		{carry_out, result} = {b, shift_c};
	ALU_SHR:
		{result, carry_out} = {shift_c, b};
	ALU_INC:
		{carry_out, result} = {1'b0, a} + 9'd1;
	default: begin
		result = a;
		carry_out = 1'b0;
	end
	endcase
end

endmodule

`default_nettype wire

// ==== logic/mos8_execute.sv ====
`default_nettype none

`include "mos8_consts.svh"

module mos8_execute import mos8_isa_pkg::*, mos8_uop_pkg::*; (
	input logic clk,
	input logic n_reset,
	input logic uop_valid,
	input alu_op_t uop_alu,
	input src_t uop_src,
	input dst_t uop_dst,
	input flag_upd_t uop_flags,
	input store_t uop_store,
	input logic uop_carry_in,
	input byte_t uop_arg,
	output logic wr_valid,
	output addr_t wr_addr,
	output byte_t wr_data
);

byte_t reg_a, reg_x, reg_sp, reg_p;
byte_t alu_a, alu_b, alu_res;
byte_t nxt_p;
logic alu_c, alu_v;

always_comb
	case (uop_src)
	SRC_ARG:	alu_a = uop_arg;
	SRC_X:		alu_a = reg_x;
	default:	alu_a = reg_a;
	endcase

// Shifts work on b, which is A for the accumulator forms
assign alu_b = (uop_alu == ALU_SHL || uop_alu == ALU_SHR) ? reg_a : uop_arg;

mos8_alu alu_inst (
	.op(uop_alu),
	.a(alu_a),
	.b(alu_b),
	.carry(reg_p[`ST_C]),
	.carry_in_en(uop_carry_in),
	.result(alu_res),
	.carry_out(alu_c),
	.overflow(alu_v)
);

always_comb begin
	nxt_p = reg_p;
	if (uop_flags == FLG_NZ || uop_flags == FLG_NZC || uop_flags == FLG_NVZC) begin
		nxt_p[`ST_N] = alu_res[7];
		nxt_p[`ST_Z] = (alu_res == 8'h00);
	end
	if (uop_flags == FLG_NZC || uop_flags == FLG_NVZC)
		nxt_p[`ST_C] = alu_c;
	if (uop_flags == FLG_NVZC)
		nxt_p[`ST_V] = alu_v;
	if (uop_flags == FLG_CLR_C)
		nxt_p[`ST_C] = 1'b0;
	if (uop_flags == FLG_SET_C)
		nxt_p[`ST_C] = 1'b1;
end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		reg_a <= 8'h00;
		reg_x <= 8'h00;
		reg_sp <= `SP_RESET;
		reg_p <= `P_RESET;
		wr_valid <= 1'b0;
	end else begin
		wr_valid <= uop_valid && uop_store != STORE_NONE;
		if (uop_valid) begin
			reg_p <= nxt_p;
			if (uop_dst == DST_A)
				reg_a <= alu_res;
			if (uop_dst == DST_X)
				reg_x <= alu_res;
			if (uop_store == STORE_PUSH_P)
				reg_sp <= reg_sp - 8'd1;
		end
	end

always_ff @(posedge clk)
	case (uop_store)
	STORE_A_ZP:	{wr_addr, wr_data} <= {8'h00, uop_arg, reg_a};
	STORE_X_ZP:	{wr_addr, wr_data} <= {8'h00, uop_arg, reg_x};
	STORE_PUSH_P:	{wr_addr, wr_data} <= {`STACK_PAGE, reg_sp, reg_p | `P_PUSH_MASK};
	default:	;
	endcase

endmodule

`default_nettype wire

// ==== logic/mos8_pipe_top.sv ====
`default_nettype none

module mos8_pipe_top import mos8_isa_pkg::*, mos8_uop_pkg::*; (
	input logic clk,
	input logic n_reset,
	input logic byte_valid,
	input byte_t byte_data,
	output logic wr_valid,
	output addr_t wr_addr,
	output byte_t wr_data,
	output logic illegal
);

logic ins_valid;
byte_t ins_op, ins_arg;

logic uop_valid, uop_carry_in;
alu_op_t uop_alu;
src_t uop_src;
dst_t uop_dst;
flag_upd_t uop_flags;
store_t uop_store;
byte_t uop_arg;

mos8_fetch fetch_inst (
	.clk, .n_reset, .byte_valid, .byte_data,
	.ins_valid, .ins_op, .ins_arg
);

mos8_decode decode_inst (
	.clk, .n_reset, .ins_valid, .ins_op, .ins_arg,
	.uop_valid, .uop_alu, .uop_src, .uop_dst, .uop_flags, .uop_store,
	.uop_carry_in, .uop_arg, .illegal
);

mos8_execute execute_inst (
	.clk, .n_reset,
	.uop_valid, .uop_alu, .uop_src, .uop_dst, .uop_flags, .uop_store,
	.uop_carry_in, .uop_arg,
	.wr_valid, .wr_addr, .wr_data
);

endmodule

`default_nettype wire

// ==== test/mos8_pipe_checker.sv ====
`default_nettype none

module mos8_pipe_checker import mos8_isa_pkg::*; (
	input logic clk,
	input logic n_reset,
	input logic byte_valid,
	input logic wr_valid,
	input addr_t wr_addr,
	input logic illegal
);

timeunit 1ns;
timeprecision 1ns;

int fail_count = 0;

strobes_known: assert property (@(posedge clk) disable iff (!n_reset)
		!$isunknown({byte_valid, wr_valid, illegal}))
	else begin
		$error("A strobe is unknown after reset");
		fail_count++;
	end

// Three stages between the last byte and the write
write_latency: assert property (@(posedge clk) disable iff (!n_reset)
		wr_valid |-> $past(byte_valid, 3))
	else begin
		$error("Write strobe without a byte strobe three cycles before");
		fail_count++;
	end

illegal_latency: assert property (@(posedge clk) disable iff (!n_reset)
		illegal |-> $past(byte_valid, 2))
	else begin
		$error("Illegal strobe without a byte strobe two cycles before");
		fail_count++;
	end

// Zero page or stack page only
write_page: assert property (@(posedge clk) disable iff (!n_reset)
		wr_valid |-> (wr_addr[15:8] == 8'h00 || wr_addr[15:8] == 8'h01))
	else begin
		$error("Write address outside page 0 and page 1");
		fail_count++;
	end

endmodule

bind mos8_pipe_top mos8_pipe_checker checker_inst (
	.clk, .n_reset, .byte_valid, .wr_valid, .wr_addr, .illegal
);

`default_nettype wire

// ==== test/mos8_pipe_tb.sv ====
`default_nettype none

`include "mos8_consts.svh"

module mos8_pipe_tb import mos8_isa_pkg::*, mos8_uop_pkg::*; ();

timeunit 1ns;
timeprecision 1ns;

typedef struct packed {
	logic is_illegal;
	addr_t addr;
	byte_t data;
} exp_event_t;

// Opcode in the high byte and operand in the low byte
localparam logic [15:0] DIRECTED [81] = '{
	// Loads, transfers and zero page stores
	16'hA95A, 16'h8510, 16'hA2C3, 16'h8611, 16'hAA00, 16'h8612, 16'hA900, 16'h8A00,
	16'h8513, 16'hE800, 16'h8614, 16'hA2FF, 16'hE800, 16'h8615, 16'h0800, 16'hA980,
	16'h85FF,
	// ADC and SBC chains
	16'h1800, 16'hA950, 16'h6950, 16'h0800, 16'h8520, 16'h69F0, 16'h0800, 16'h8521,
	16'h3800, 16'hA950, 16'hE9F0, 16'h0800, 16'h8522, 16'h1800, 16'hE901, 16'h0800,
	16'h8523, 16'h3800, 16'hA900, 16'hE900, 16'h0800, 16'hA9FF, 16'h6901, 16'h0800,
	16'h8524, 16'hA97F, 16'h6901, 16'h0800, 16'h3800, 16'hA980, 16'hE901, 16'h0800,
	16'h8525,
	// Logic ops, shifts and rotates
	16'hA9F0, 16'h293C, 16'h8530, 16'h0903, 16'h8531, 16'h49FF, 16'h8532, 16'h0800,
	16'h3800, 16'hA981, 16'h2A00, 16'h0800, 16'h8533, 16'h6A00, 16'h0800, 16'h8534,
	16'h6A00, 16'h0800, 16'h8535, 16'h1800, 16'h0A00, 16'h0800, 16'h8536, 16'h4A00,
	16'h4A00, 16'h0800, 16'h8537, 16'h3800, 16'h6A00, 16'h8538, 16'h0800
};

logic clk, n_reset, byte_valid, wr_valid, illegal;
byte_t byte_data, wr_data;
addr_t wr_addr;

byte_t model_a, model_x, model_sp, model_p;
byte_t prog_bytes[$];
int prog_gaps[$];
exp_event_t exp_q[$];
logic [31:0] rng_state = 32'h37dd_fb5b;
int mismatch_count = 0;
int unexpected_count = 0;
int watchdog_cycles = 0;
logic build_done = 1'b0;

mos8_pipe_top mos8_pipe_top_inst (
	.clk, .n_reset, .byte_valid, .byte_data,
	.wr_valid, .wr_addr, .wr_data, .illegal
);

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	return x ^ (x << 5);
endfunction

function automatic logic [31:0] rand_next();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

function automatic int to_signed(input byte_t b);
	return b[7] ? int'(b) - 256 : int'(b);
endfunction

function automatic opcode_t pick_supported(input int k);
	opcode_t op;
	op = op.first();
	repeat (k % op.num())
		op = op.next();
	return op;
endfunction

// Reference model of one instruction
function automatic void model_step(input byte_t op, input byte_t arg);
	int u;
	int s;
	byte_t res;
	dst_t dst;
	res = 8'h00;
	dst = DST_A;
	case (op)
	LDA_IMM: res = arg;
	LDX_IMM: begin
		res = arg;
		dst = DST_X;
	end
	AND_IMM: res = model_a & arg;
	ORA_IMM: res = model_a | arg;
	EOR_IMM: res = model_a ^ arg;
	ADC_IMM: begin
		u = int'(model_a) + int'(arg) + int'(model_p[`ST_C]);
		s = to_signed(model_a) + to_signed(arg) + int'(model_p[`ST_C]);
		model_p[`ST_C] = (u > 255);
		model_p[`ST_V] = (s > 127) || (s < -128);
		res = u[7:0];
	end
	SBC_IMM: begin
		// Borrow is the inverted carry
		u = int'(model_a) - int'(arg) - int'(!model_p[`ST_C]);
		s = to_signed(model_a) - to_signed(arg) - int'(!model_p[`ST_C]);
		model_p[`ST_C] = (u >= 0);
		model_p[`ST_V] = (s > 127) || (s < -128);
		res = u[7:0];
	end
	ASL_A, ROL_A: begin
		res = {model_a[6:0], (op == ROL_A) & model_p[`ST_C]};
		model_p[`ST_C] = model_a[7];
	end
	LSR_A, ROR_A: begin
		res = {(op == ROR_A) & model_p[`ST_C], model_a[7:1]};
		model_p[`ST_C] = model_a[0];
	end
	CLC: begin
		model_p[`ST_C] = 1'b0;
		dst = DST_NONE;
	end
	SEC: begin
		model_p[`ST_C] = 1'b1;
		dst = DST_NONE;
	end
	TAX: begin
		res = model_a;
		dst = DST_X;
	end
	TXA: res = model_x;
	INX: begin
		res = model_x + 8'd1;
		dst = DST_X;
	end
	STA_ZP: begin
		exp_q.push_back({1'b0, 8'h00, arg, model_a});
		dst = DST_NONE;
	end
	STX_ZP: begin
		exp_q.push_back({1'b0, 8'h00, arg, model_x});
		dst = DST_NONE;
	end
	PHP: begin
		exp_q.push_back({1'b0, `STACK_PAGE, model_sp, model_p | `P_PUSH_MASK});
		model_sp = model_sp - 8'd1;
		dst = DST_NONE;
	end
	default: begin
		exp_q.push_back({1'b1, 16'h0000, op});
		dst = DST_NONE;
	end
	endcase
	if (dst == DST_A)
		model_a = res;
	if (dst == DST_X)
		model_x = res;
	if (dst != DST_NONE) begin
		model_p[`ST_N] = res[7];
		model_p[`ST_Z] = (res == 8'h00);
	end
endfunction

// One byte when bit 3 is set and bit 0 is clear
function automatic void add_ins(input byte_t op, input byte_t arg, input int gap);
	prog_bytes.push_back(op);
	prog_gaps.push_back(gap);
	if (op[3] && !op[0]) begin
		model_step(op, 8'h00);
	end else begin
		prog_bytes.push_back(arg);
		prog_gaps.push_back(gap);
		model_step(op, arg);
	end
endfunction

task automatic check_strobe(input logic got_illegal);
	exp_event_t ev;
	assert (exp_q.size() > 0) else begin
		$display("Unexpected %s strobe at time %0t",
			got_illegal ? "illegal" : "write", $time);
		unexpected_count++;
	end
	if (exp_q.size() == 0)
		return;
	ev = exp_q.pop_front();
	assert (ev.is_illegal == got_illegal) else begin
		$display("[ERROR] %0t: got %s strobe, expected %s", $time,
			got_illegal ? "illegal" : "write", ev.is_illegal ? "illegal" : "write");
		mismatch_count++;
	end
	if (got_illegal || ev.is_illegal)
		return;
	assert (wr_addr == ev.addr) else begin
		$display("[ERROR] %0t: write address %h, expected %h", $time, wr_addr, ev.addr);
		mismatch_count++;
	end
	assert (wr_data == ev.data) else begin
		$display("[ERROR] %0t: write data %h to %h, expected %h", $time, wr_data, wr_addr,
			ev.data);
		mismatch_count++;
	end
endtask

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

// Outputs change on the rising edge and are sampled on the falling one
initial begin
	forever begin
		@(negedge clk);
		if (n_reset && wr_valid)
			check_strobe(1'b0);
		if (n_reset && illegal)
			check_strobe(1'b1);
	end
end

initial begin
	wait (build_done);
	repeat (watchdog_cycles) @(posedge clk);
	$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
	$display("TEST RESULT: FAIL");
	$finish;
end

initial begin
	int drain;
	int checker_fails;
	logic [31:0] r;
	byte_t op;
	n_reset = 1'b0;
	byte_valid = 1'b0;
	byte_data = 8'h00;
	model_a = 8'h00;
	model_x = 8'h00;
	model_sp = `SP_RESET;
	model_p = `P_RESET;
	// Long enough for SP to wrap within page 1
	for (int i = 0; i < 260; i++)
		add_ins(PHP, 8'h00, 0);
	for (int i = 0; i < $size(DIRECTED); i++)
		add_ins(DIRECTED[i][15:8], DIRECTED[i][7:0], 0);
	for (int i = 0; i < 300; i++) begin
		r = rand_next();
		op = r[0] ? pick_supported(int'(r[15:8])) : r[23:16];
		add_ins(op, r[31:24], r[1] ? int'(r[3:2]) : 0);
	end
	add_ins(STA_ZP, 8'h40, 0);
	add_ins(STX_ZP, 8'h41, 0);
	add_ins(PHP, 8'h00, 0);
	watchdog_cycles = prog_bytes.size() * 4 + 200;
	build_done = 1'b1;

	repeat (16) @(negedge clk);
	n_reset = 1'b1;
	foreach (prog_bytes[i]) begin
		repeat (prog_gaps[i]) begin
			@(negedge clk);
			byte_valid = 1'b0;
		end
		@(negedge clk);
		byte_valid = 1'b1;
		byte_data = prog_bytes[i];
	end
	@(negedge clk);
	byte_valid = 1'b0;

	drain = 0;
	while (exp_q.size() > 0 && drain < 20) begin
		@(negedge clk);
		drain++;
	end
	repeat (4) @(negedge clk);

	checker_fails = mos8_pipe_top_inst.checker_inst.fail_count;
	$display("Error counts: %0d mismatched, %0d unexpected, %0d assertion, %0d still expected",
		mismatch_count, unexpected_count, checker_fails, exp_q.size());
	if (mismatch_count == 0 && unexpected_count == 0 && checker_fails == 0 && exp_q.size() == 0)
		$display("TEST RESULT: PASS");
	else
		$display("TEST RESULT: FAIL");
	$finish;
end

endmodule

`default_nettype wire

// ==== mos8_pipe.f ====
+incdir+include
logic/mos8_isa_pkg.sv
logic/mos8_uop_pkg.sv
logic/mos8_fetch.sv
logic/mos8_decode.sv
logic/mos8_alu.sv
logic/mos8_execute.sv
logic/mos8_pipe_top.sv
test/mos8_pipe_checker.sv
test/mos8_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the pipeline testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f mos8_pipe.f --top-module mos8_pipe_tb -o mos8_pipe_sim \
	&& ./obj_dir/mos8_pipe_sim +verilator+error+limit+100000 | tee sim.log \
	|| echo "Verilator build or run failed"

grep -qsx "TEST RESULT: PASS" sim.log && echo "Pass line found in sim.log" \
	|| { echo "No pass line in sim.log"; exit 1; }
